// ==== common/exu_pkg.sv ====
package exu_pkg;

    // data and address width
    localparam int xlen = 64;
    // register index width
    localparam int reg_addr_w = 5;
    // number of one-hot instruction classes
    localparam int op_class_w = 11;

    // bit positions in the one-hot class vector
    localparam int cls_lui       = 0;
    localparam int cls_auipc     = 1;
    localparam int cls_jal       = 2;
    localparam int cls_jalr      = 3;
    localparam int cls_branch    = 4;
    localparam int cls_load      = 5;
    localparam int cls_store     = 6;
    localparam int cls_alu_imm   = 7;
    localparam int cls_alu_reg   = 8;
    // word forms, 32-bit result sign-extended
    localparam int cls_alu_imm_w = 9;
    localparam int cls_alu_reg_w = 10;

    // one-hot class word from decode
    typedef logic [op_class_w-1:0] op_class_t;

    // alu operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // record handed over by decode
    // imm[10] doubles as the funct7 bit, imm[5] as the word-shift marker
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [31:0]           inst;
        op_class_t             op_class;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       src_a;
        logic [xlen-1:0]       src_b;
        logic [xlen-1:0]       imm;
    } id_ex_t;

    // writeback intent of a later stage, for forwarding
    typedef struct packed {
        logic                  writing;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } bypass_t;

    // record handed on to memory
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [31:0]           inst;
        op_class_t             op_class;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
    } ex_mem_t;

endpackage

// ==== execute/exu_stage_reg.sv ====
`timescale 1ns/1ps

module exu_stage_reg (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            load,
    input  exu_pkg::id_ex_t id_ex,
    input  logic            valid_id_ex,
    output exu_pkg::id_ex_t stage,
    output logic            stage_valid
);

    // valid bit of the instruction sitting in EX
    // flush drops it just like reset does
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stage_valid <= 1'b0;
        end else if (load) begin
            // a bubble from decode loads as invalid
            stage_valid <= valid_id_ex;
        end
    end

    // instruction record
    // cleared too, so a killed instruction leaves nothing behind
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stage <= '0;
        end else if (load) begin
            stage <= id_ex;
        end
        // no load means memory is stalled
        // keep the record so the same instruction re-presents
    end

endmodule

// ==== execute/exu_bypass.sv ====
`timescale 1ns/1ps

module exu_bypass (
    input  exu_pkg::id_ex_t               stage,
    input  exu_pkg::bypass_t              mem_bypass,
    input  exu_pkg::bypass_t              wb_bypass,
    output logic [exu_pkg::xlen-1:0]      src1,
    output logic [exu_pkg::xlen-1:0]      src2
);

    import exu_pkg::*;

    logic rs2_used;

    // pick the newest value for one source register
    // memory is younger than writeback, so it is checked first
    function automatic logic [xlen-1:0] forward(
        input logic [reg_addr_w-1:0] rs,
        input logic [xlen-1:0]       reg_val,
        input logic                  used,
        input bypass_t               mem,
        input bypass_t               wb
    );
        logic live;
        logic mem_hit;
        logic wb_hit;
        begin
            // x0 is hardwired, never take a forwarded value for it
            live    = used && (rs != '0);
            mem_hit = live && mem.writing && (mem.rd == rs);
            wb_hit  = live && wb.writing && (wb.rd == rs);
            if (mem_hit) begin
                forward = mem.data;
            end else if (wb_hit) begin
                forward = wb.data;
            end else begin
                forward = reg_val;
            end
        end
    endfunction

    // only these classes read rs2
    // immediate forms carry garbage in the rs2 field
    assign rs2_used = stage.op_class[cls_branch]
                    | stage.op_class[cls_store]
                    | stage.op_class[cls_alu_reg]
                    | stage.op_class[cls_alu_reg_w];

    // rs1 is forwarded for every class
    assign src1 = forward(stage.rs1, stage.src_a, 1'b1, mem_bypass, wb_bypass);
    assign src2 = forward(stage.rs2, stage.src_b, rs2_used, mem_bypass, wb_bypass);

endmodule

// ==== execute/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu #(
    parameter int xlen       = exu_pkg::xlen,
    parameter int op_class_w = exu_pkg::op_class_w
) (
    input  exu_pkg::id_ex_t   stage,
    input  logic [xlen-1:0]   src1,
    input  logic [xlen-1:0]   src2,
    output logic [xlen-1:0]   result,
    output logic [xlen-1:0]   alu_out
);

    import exu_pkg::*;

    localparam int half = xlen / 2;

    logic [op_class_w-1:0] cls;
    logic [2:0]            funct3;
    logic                  funct7_bit;
    logic                  is_int;
    logic                  is_word;
    logic                  is_reg;
    logic                  is_shift;
    logic                  word_rshift;
    logic                  use_imm;
    logic [xlen-1:0]       operator_a;
    logic [xlen-1:0]       operator_b;
    alu_op_t               alu_op;

    assign cls        = stage.op_class;
    assign funct3     = stage.funct3;
    assign funct7_bit = stage.imm[10];

    // class groups
    assign is_int   = cls[cls_alu_imm] | cls[cls_alu_reg];
    assign is_word  = cls[cls_alu_imm_w] | cls[cls_alu_reg_w];
    assign is_reg   = cls[cls_alu_reg] | cls[cls_alu_reg_w];
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // srlw, sraw, srliw, sraiw
    // these run in the upper half so the 64-bit shifter fills the right bits
    assign word_rshift = is_word && (funct3 == 3'b101) && !stage.imm[5];

    // classes whose second operand is the immediate
    assign use_imm = cls[cls_lui] | cls[cls_auipc] | cls[cls_load]
                   | cls[cls_store] | cls[cls_alu_imm] | cls[cls_alu_imm_w];

    // operator a
    always_comb begin
        if (cls[cls_lui]) begin
            operator_a = '0;
        end else if (cls[cls_auipc] || cls[cls_jal] || cls[cls_jalr]) begin
            operator_a = stage.pc;
        end else if (word_rshift) begin
            operator_a = {src1[half-1:0], {half{1'b0}}};
        end else begin
            operator_a = src1;
        end
    end

    // operator b
    // shift amounts are 6 bits wide, 5 bits for word shifts
    always_comb begin
        if (cls[cls_jal] || cls[cls_jalr]) begin
            // link address is pc plus 4
            operator_b = xlen'(4);
        end else if (cls[cls_alu_reg] && is_shift) begin
            operator_b = {{(xlen-6){1'b0}}, src2[5:0]};
        end else if (cls[cls_alu_reg_w] && is_shift) begin
            operator_b = {{(xlen-5){1'b0}}, src2[4:0]};
        end else if (cls[cls_alu_imm] && is_shift) begin
            operator_b = {{(xlen-6){1'b0}}, stage.imm[5:0]};
        end else if (cls[cls_alu_imm_w] && is_shift) begin
            operator_b = {{(xlen-5){1'b0}}, stage.imm[4:0]};
        end else if (use_imm) begin
            operator_b = stage.imm;
        end else begin
            operator_b = src2;
        end
    end

    // operation decode
    always_comb begin
        alu_op = alu_add;
        if (cls[cls_branch]) begin
            // branch compares go through the subtractor
            alu_op = alu_sub;
        end else if (is_int || is_word) begin
            case (funct3)
                3'b000: alu_op = (is_reg && funct7_bit) ? alu_sub : alu_add;
                3'b001: alu_op = alu_sll;
                3'b010: alu_op = is_int ? alu_slt : alu_add;
                3'b011: alu_op = is_int ? alu_sltu : alu_add;
                3'b100: alu_op = is_int ? alu_xor : alu_add;
                3'b101: alu_op = funct7_bit ? alu_sra : alu_srl;
                3'b110: alu_op = is_int ? alu_or : alu_add;
                3'b111: alu_op = is_int ? alu_and : alu_add;
                default: alu_op = alu_add;
            endcase
        end
    end

    // raw arithmetic
    always_comb begin
        case (alu_op)
            alu_add:  result = operator_a + operator_b;
            alu_sub:  result = operator_a - operator_b;
            alu_slt:  result = xlen'($signed(operator_a) < $signed(operator_b));
            alu_sltu: result = xlen'(operator_a < operator_b);
            alu_and:  result = operator_a & operator_b;
            alu_or:   result = operator_a | operator_b;
            alu_xor:  result = operator_a ^ operator_b;
            alu_sll:  result = operator_a << operator_b[5:0];
            alu_srl:  result = operator_a >> operator_b[5:0];
            alu_sra:  result = $signed(operator_a) >>> operator_b[5:0];
            default:  result = operator_a + operator_b;
        endcase
    end

    // word results are sign-extended from the half that holds them
    always_comb begin
        if (word_rshift) begin
            alu_out = {{half{result[xlen-1]}}, result[xlen-1:half]};
        end else if (is_word) begin
            alu_out = {{half{result[half-1]}}, result[half-1:0]};
        end else begin
            alu_out = result;
        end
    end

endmodule

// ==== execute/exu_branch.sv ====
`timescale 1ns/1ps

module exu_branch (
    input  exu_pkg::id_ex_t          stage,
    input  logic                     stage_valid,
    input  logic                     ready_ex_mem,
    input  logic [exu_pkg::xlen-1:0] src1,
    input  logic [exu_pkg::xlen-1:0] src2,
    input  logic [exu_pkg::xlen-1:0] alu_result,
    output logic [exu_pkg::xlen-1:0] dnpc,
    output logic                     pc_update
);

    import exu_pkg::*;

    logic            is_jump;
    logic            is_branch;
    logic            equal;
    logic            less_s;
    logic            less_u;
    logic            taken;
    logic            predicted;
    logic            redirect;
    logic [xlen-1:0] target;
    logic [xlen-1:0] snpc;

    assign is_jump   = stage.op_class[cls_jal] | stage.op_class[cls_jalr];
    assign is_branch = stage.op_class[cls_branch];

    // compares from src1 - src2 and the operand signs
    assign equal  = (alu_result == '0);
    assign less_s = (src1[xlen-1] & ~src2[xlen-1])
                  | (alu_result[xlen-1] & (src1[xlen-1] == src2[xlen-1]));
    assign less_u = (~src1[xlen-1] & src2[xlen-1])
                  | (alu_result[xlen-1] & (src1[xlen-1] == src2[xlen-1]));

    always_comb begin
        case (stage.funct3)
            3'b000:  taken = equal;
            3'b001:  taken = !equal;
            3'b100:  taken = less_s;
            3'b101:  taken = !less_s;
            3'b110:  taken = less_u;
            3'b111:  taken = !less_u;
            default: taken = 1'b0;
        endcase
    end

    // decode guessed backward taken, forward not taken
    assign predicted = stage.imm[xlen-1];

    // jalr adds to src1 and keeps bit 0 as is
    assign target = (stage.op_class[cls_jalr] ? src1 : stage.pc) + stage.imm;
    assign snpc   = stage.pc + xlen'(4);

    assign dnpc = (is_jump || (is_branch && taken)) ? target : snpc;

    // jumps always redirect, branches only on a wrong guess
    assign redirect  = is_jump || (is_branch && (taken != predicted));
    // only while memory takes the instruction this cycle
    assign pc_update = stage_valid && ready_ex_mem && redirect;

endmodule

// ==== source/exu_top.sv ====
`timescale 1ns/1ps

module exu_top #(
    parameter int xlen = exu_pkg::xlen
) (
    input  logic              clk,
    input  logic              rst,
    input  exu_pkg::id_ex_t   id_ex,
    input  logic              valid_id_ex,
    output logic              ready_id_ex,
    output exu_pkg::ex_mem_t  ex_mem,
    output logic              valid_ex_mem,
    input  logic              ready_ex_mem,
    input  exu_pkg::bypass_t  mem_bypass,
    input  exu_pkg::bypass_t  wb_bypass,
    input  logic              flush,
    output logic [xlen-1:0]   dnpc,
    output logic              pc_update
);

    import exu_pkg::*;

    id_ex_t          stage;
    logic            stage_valid;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_raw;
    logic [xlen-1:0] alu_out;

    // single-cycle stage, so decode may advance whenever memory does
    assign ready_id_ex  = ready_ex_mem;
    assign valid_ex_mem = stage_valid;

    exu_stage_reg u_stage_reg (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .load        (ready_id_ex),
        .id_ex       (id_ex),
        .valid_id_ex (valid_id_ex),
        .stage       (stage),
        .stage_valid (stage_valid)
    );

    exu_bypass u_bypass (
        .stage      (stage),
        .mem_bypass (mem_bypass),
        .wb_bypass  (wb_bypass),
        .src1       (src1),
        .src2       (src2)
    );

    exu_alu #(
        .xlen       (xlen),
        .op_class_w (op_class_w)
    ) u_alu (
        .stage   (stage),
        .src1    (src1),
        .src2    (src2),
        .result  (alu_raw),
        .alu_out (alu_out)
    );

    // branch compare uses the raw subtract, not the word-adjusted value
    exu_branch u_branch (
        .stage        (stage),
        .stage_valid  (stage_valid),
        .ready_ex_mem (ready_ex_mem),
        .src1         (src1),
        .src2         (src2),
        .alu_result   (alu_raw),
        .dnpc         (dnpc),
        .pc_update    (pc_update)
    );

    // record toward memory
    always_comb begin
        ex_mem.pc         = stage.pc;
        ex_mem.inst       = stage.inst;
        ex_mem.op_class   = stage.op_class;
        ex_mem.funct3     = stage.funct3;
        ex_mem.rd         = stage.rd;
        ex_mem.rs2        = stage.rs2;
        ex_mem.alu_result = alu_out;
        // store data must see forwarded rs2
        ex_mem.store_data = src2;
    end

endmodule

// ==== sim/exu_assert.sv ====
`timescale 1ns/1ps

module exu_assert (
    input logic             clk,
    input logic             rst,
    input logic             flush,
    input logic             ready_id_ex,
    input logic             ready_ex_mem,
    input logic             valid_ex_mem,
    input exu_pkg::ex_mem_t ex_mem,
    input logic             pc_update
);

    int fail_count = 0;

    // single-cycle stage, decode follows memory
    a_ready_follow: assert property (@(posedge clk) disable iff (rst)
        ready_id_ex == ready_ex_mem)
        else begin
            $error("ready_id_ex does not follow ready_ex_mem");
            fail_count++;
        end

    // held instruction re-presents unchanged
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (valid_ex_mem && !ready_ex_mem && !flush) |=> (valid_ex_mem && $stable(ex_mem)))
        else begin
            $error("the stalled instruction changed or vanished");
            fail_count++;
        end

    // no redirect while memory is stalled
    a_stall_redirect: assert property (@(posedge clk) disable iff (rst)
        !ready_ex_mem |-> !pc_update)
        else begin
            $error("pc_update was raised while memory was stalled");
            fail_count++;
        end

    // reset or flush leaves the stage empty
    a_clear: assert property (@(posedge clk)
        (rst || flush) |=> (!valid_ex_mem && !pc_update))
        else begin
            $error("the stage was not empty after reset or flush");
            fail_count++;
        end

endmodule

bind exu_top exu_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .ready_id_ex  (ready_id_ex),
    .ready_ex_mem (ready_ex_mem),
    .valid_ex_mem (valid_ex_mem),
    .ex_mem       (ex_mem),
    .pc_update    (pc_update)
);

// ==== sim/exu_tb.sv ====
`timescale 1ns/1ps

module exu_tb;

    import exu_pkg::*;

    localparam int n_directed = 48;
    localparam int n_random   = 2000;
    localparam int period     = 8;

    logic            clk;
    logic            rst;
    id_ex_t          id_ex;
    logic            valid_id_ex;
    logic            ready_id_ex;
    ex_mem_t         ex_mem;
    logic            valid_ex_mem;
    logic            ready_ex_mem;
    bypass_t         mem_bypass;
    bypass_t         wb_bypass;
    logic            flush;
    logic [xlen-1:0] dnpc;
    logic            pc_update;

    logic [31:0]     seed;
    // accepted instructions, at most one in flight
    id_ex_t          accepted[$];
    id_ex_t          held;
    logic            held_valid;
    logic [xlen-1:0] exp_src1;
    logic [xlen-1:0] exp_src2;
    logic [xlen-1:0] exp_alu;
    logic [xlen-1:0] exp_dnpc;
    logic            exp_pcu;
    // bypass traffic last driven, frozen while memory stalls
    bypass_t         last_mb;
    bypass_t         last_wb;
    logic            last_rdy;

    exu_top #(.xlen(xlen)) u_dut (
        .clk          (clk),
        .rst          (rst),
        .id_ex        (id_ex),
        .valid_id_ex  (valid_id_ex),
        .ready_id_ex  (ready_id_ex),
        .ex_mem       (ex_mem),
        .valid_ex_mem (valid_ex_mem),
        .ready_ex_mem (ready_ex_mem),
        .mem_bypass   (mem_bypass),
        .wb_bypass    (wb_bypass),
        .flush        (flush),
        .dnpc         (dnpc),
        .pc_update    (pc_update)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // xorshift32 step
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        begin
            y = x ^ (x << 13);
            y = y ^ (y >> 17);
            y = y ^ (y << 5);
            return y;
        end
    endfunction

    function logic [31:0] rnd();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic [xlen-1:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // newest value of a source register, memory before writeback
    function automatic logic [xlen-1:0] pick_src(input logic [4:0] idx,
            input logic [xlen-1:0] reg_val, input logic used,
            input bypass_t mb, input bypass_t wb);
        if (used && idx != 5'd0 && mb.writing && mb.rd == idx) return mb.data;
        if (used && idx != 5'd0 && wb.writing && wb.rd == idx) return wb.data;
        return reg_val;
    endfunction

    function automatic logic reads_rs2(input op_class_t c);
        return c[cls_branch] | c[cls_store] | c[cls_alu_reg] | c[cls_alu_reg_w];
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // expected alu result from the instruction rules
    function automatic logic [xlen-1:0] model_alu(input id_ex_t r,
            input logic [xlen-1:0] s1, input logic [xlen-1:0] s2);
        logic [xlen-1:0] b;
        logic [31:0]     w;
        logic            f7;
        logic            is_reg;
        begin
            f7 = r.imm[10];
            is_reg = r.op_class[cls_alu_reg] | r.op_class[cls_alu_reg_w];
            b = is_reg ? s2 : r.imm;
            if (r.op_class[cls_lui]) return r.imm;
            if (r.op_class[cls_auipc]) return r.pc + r.imm;
            if (r.op_class[cls_jal] || r.op_class[cls_jalr]) return r.pc + 64'd4;
            if (r.op_class[cls_load] || r.op_class[cls_store]) return s1 + r.imm;
            if (r.op_class[cls_branch]) return s1 - s2;
            if (r.op_class[cls_alu_reg] || r.op_class[cls_alu_imm]) begin
                case (r.funct3)
                    3'd0: return (is_reg && f7) ? s1 - b : s1 + b;
                    3'd1: return s1 << b[5:0];
                    3'd2: return {63'd0, $signed(s1) < $signed(b)};
                    3'd3: return {63'd0, s1 < b};
                    3'd4: return s1 ^ b;
                    3'd5: begin
                        // arithmetic shift kept apart so it stays signed
                        if (f7) return $signed(s1) >>> b[5:0];
                        return s1 >> b[5:0];
                    end
                    3'd6: return s1 | b;
                    default: return s1 & b;
                endcase
            end
            // word forms work on 32 bits, then sign-extend
            case (r.funct3)
                3'd1:    w = s1[31:0] << b[4:0];
                3'd5: begin
                    if (f7) begin
                        w = $signed(s1[31:0]) >>> b[4:0];
                    end else begin
                        w = s1[31:0] >> b[4:0];
                    end
                end
                default: w = (is_reg && f7) ? s1[31:0] - b[31:0] : s1[31:0] + b[31:0];
            endcase
            return sext32(w);
        end
    endfunction

    always @(posedge clk) begin
        if (rst || flush) begin
            accepted.delete();
        end else if (ready_ex_mem) begin
            if (accepted.size() > 0) begin
                void'(accepted.pop_front());
            end
            if (valid_id_ex) begin
                accepted.push_back(id_ex);
            end
        end
        held_valid <= accepted.size() != 0;
        held <= (accepted.size() != 0) ? accepted[0] : '0;
    end

    always_comb begin
        exp_src1 = pick_src(held.rs1, held.src_a, 1'b1, mem_bypass, wb_bypass);
        exp_src2 = pick_src(held.rs2, held.src_b, reads_rs2(held.op_class),
                            mem_bypass, wb_bypass);
        exp_alu = model_alu(held, exp_src1, exp_src2);
        if (held.op_class[cls_jalr]) begin
            exp_dnpc = exp_src1 + held.imm;
        end else if (held.op_class[cls_jal] ||
                     branch_taken(held.funct3, exp_src1, exp_src2)) begin
            exp_dnpc = held.pc + held.imm;
        end else begin
            exp_dnpc = held.pc + 64'd4;
        end
        // a branch redirects when it disagrees with backward-taken
        exp_pcu = held_valid && ready_ex_mem &&
                  (held.op_class[cls_jal] || held.op_class[cls_jalr] ||
                   (held.op_class[cls_branch] &&
                    branch_taken(held.funct3, exp_src1, exp_src2) != held.imm[63]));
    end

    task automatic report_fail(input string name, input logic [63:0] exp_v,
            input logic [63:0] act_v);
        $display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    a_alu: assert property (@(posedge clk) disable iff (rst)
        valid_ex_mem |-> ex_mem.alu_result == exp_alu)
        else report_fail("ex_mem.alu_result", $sampled(exp_alu),
                         $sampled(ex_mem.alu_result));
    a_store: assert property (@(posedge clk) disable iff (rst)
        valid_ex_mem |-> ex_mem.store_data == exp_src2)
        else report_fail("ex_mem.store_data", $sampled(exp_src2),
                         $sampled(ex_mem.store_data));
    a_pc: assert property (@(posedge clk) disable iff (rst)
        valid_ex_mem |-> ex_mem.pc == held.pc)
        else report_fail("ex_mem.pc", $sampled(held.pc), $sampled(ex_mem.pc));
    a_inst: assert property (@(posedge clk) disable iff (rst)
        valid_ex_mem |-> ex_mem.inst == held.inst)
        else report_fail("ex_mem.inst", $sampled(held.inst), $sampled(ex_mem.inst));
    // class, funct3, rd and rs2 travel through unchanged
    a_ctrl: assert property (@(posedge clk) disable iff (rst)
        valid_ex_mem |-> {ex_mem.op_class, ex_mem.funct3, ex_mem.rd, ex_mem.rs2}
                         == {held.op_class, held.funct3, held.rd, held.rs2})
        else report_fail("ex_mem.{op_class,funct3,rd,rs2}",
                         $sampled({held.op_class, held.funct3, held.rd, held.rs2}),
                         $sampled({ex_mem.op_class, ex_mem.funct3, ex_mem.rd,
                                   ex_mem.rs2}));
    a_valid: assert property (@(posedge clk) disable iff (rst)
        valid_ex_mem == held_valid)
        else report_fail("valid_ex_mem", $sampled(held_valid), $sampled(valid_ex_mem));
    a_pcu: assert property (@(posedge clk) disable iff (rst)
        pc_update == exp_pcu)
        else report_fail("pc_update", $sampled(exp_pcu), $sampled(pc_update));
    a_dnpc: assert property (@(posedge clk) disable iff (rst)
        exp_pcu |-> dnpc == exp_dnpc)
        else report_fail("dnpc", $sampled(exp_dnpc), $sampled(dnpc));

    // stop at the first bound protocol failure
    always @(posedge clk) begin
        if (u_dut.u_assert.fail_count != 0) begin
            $display("a bound protocol check on the DUT ports failed");
            $display("Simulation FAILED");
            $fatal(1, "protocol violation");
        end
    end

    initial begin
        #((n_directed + n_random) * 20 * period);
        $display("timeout: the tests did not finish in the expected time");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic step(input id_ex_t rec, input logic v, input logic rdy,
            input logic fl, input bypass_t mb, input bypass_t wb);
        @(posedge clk);
        id_ex        <= rec;
        valid_id_ex  <= v;
        ready_ex_mem <= rdy;
        flush        <= fl;
        mem_bypass   <= mb;
        wb_bypass    <= wb;
    endtask

    function automatic id_ex_t make_rec(input int c, input logic [2:0] f3,
            input logic [63:0] imm, input logic [63:0] a, input logic [63:0] b,
            input logic [4:0] rs1, input logic [4:0] rs2);
        id_ex_t r;
        logic [31:0] t;
        begin
            t = rnd();
            r = '0;
            r.pc = 64'h8000_0000 + {46'd0, t[15:2], 2'b00};
            r.inst = rnd();
            r.op_class = op_class_t'(1) << c;
            r.funct3 = f3;
            r.rd = t[20:16];
            r.rs1 = rs1;
            r.rs2 = rs2;
            r.src_a = a;
            r.src_b = b;
            r.imm = imm;
            return r;
        end
    endfunction

    task automatic op(input int c, input logic [2:0] f3, input logic [63:0] imm,
            input logic [63:0] a, input logic [63:0] b);
        step(make_rec(c, f3, imm, a, b, 5'd1, 5'd2), 1'b1, 1'b1, 1'b0, '0, '0);
    endtask

    // one random instruction with random handshake and bypass traffic
    task automatic random_cycle();
        logic [31:0] t;
        logic [2:0]  f3;
        logic [63:0] imm;
        logic [63:0] a;
        logic [63:0] b;
        int          c;
        id_ex_t      rec;
        bypass_t     mb;
        bypass_t     wb;
        logic        rdy;
        logic [2:0]  br_f3[6];
        begin
            br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
            c = rnd() % op_class_w;
            t = rnd();
            f3 = t[2:0];
            imm = {{52{t[11]}}, t[11:0]};
            if (c == cls_branch) begin
                f3 = br_f3[rnd() % 6];
                imm = {{51{t[12]}}, t[12:1], 1'b0};
            end else if (c == cls_lui || c == cls_auipc) begin
                imm = {{32{t[31]}}, t[31:12], 12'd0};
            end else if (c == cls_alu_reg || c == cls_alu_reg_w) begin
                imm = {53'd0, t[10], 10'd0};
            end
            if (c == cls_alu_reg_w || c == cls_alu_imm_w) begin
                f3 = (t[4:3] == 2'd0) ? 3'd0 : (t[4:3] == 2'd1) ? 3'd1 : 3'd5;
                imm[5] = 1'b0;
            end
            a = {rnd(), rnd()};
            b = t[13] ? a : {rnd(), rnd()};
            rec = make_rec(c, f3, imm, a, b, 5'(rnd() % 8), 5'(rnd() % 8));
            mb = {rnd() % 2 == 0, 5'(rnd() % 8), rnd(), rnd()};
            wb = {rnd() % 2 == 0, 5'(rnd() % 8), rnd(), rnd()};
            rdy = rnd() % 4 != 0;
            // later stages stall along with memory
            if (!last_rdy) begin
                mb = last_mb;
                wb = last_wb;
            end
            last_mb  = mb;
            last_wb  = wb;
            last_rdy = rdy;
            step(rec, rnd() % 8 != 0, rdy, rnd() % 32 == 0, mb, wb);
        end
    endtask

    initial begin
        seed         = 32'h90b10e7a;
        rst          = 1'b1;
        id_ex        = '0;
        valid_id_ex  = 1'b0;
        ready_ex_mem = 1'b1;
        mem_bypass   = '0;
        wb_bypass    = '0;
        flush        = 1'b0;
        last_mb      = '0;
        last_wb      = '0;
        last_rdy     = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // 64-bit register and immediate forms
        for (int f = 0; f < 8; f++) begin
            op(cls_alu_reg, 3'(f), 64'd0, 64'hf000_0000_1234_5678, 64'd13);
        end
        op(cls_alu_reg, 3'd0, 64'h400, 64'd5, 64'd9);
        op(cls_alu_reg, 3'd5, 64'h400, 64'h8000_0000_0000_0000, 64'd63);
        op(cls_alu_imm, 3'd0, -64'sd5, 64'd3, 64'd0);
        op(cls_alu_imm, 3'd5, 64'h407, 64'hff00_0000_0000_0000, 64'd0);
        op(cls_lui, 3'd0, 64'hffff_ffff_8765_4000, 64'd0, 64'd0);
        op(cls_auipc, 3'd0, 64'h1000, 64'd0, 64'd0);
        op(cls_load, 3'd3, 64'h10, 64'h2000, 64'd0);
        op(cls_store, 3'd3, -64'sd8, 64'h2000, 64'hdead_beef);
        // word forms
        op(cls_alu_reg_w, 3'd0, 64'd0, 64'h7fff_ffff, 64'd1);
        op(cls_alu_reg_w, 3'd0, 64'h400, 64'd0, 64'd1);
        op(cls_alu_reg_w, 3'd1, 64'd0, 64'h1, 64'd31);
        op(cls_alu_reg_w, 3'd5, 64'd0, 64'h8000_0000, 64'd4);
        op(cls_alu_reg_w, 3'd5, 64'h400, 64'h8000_0000, 64'd4);
        op(cls_alu_imm_w, 3'd5, 64'h3, 64'hf000_0000, 64'd0);
        op(cls_alu_imm_w, 3'd5, 64'h403, 64'hf000_0000, 64'd0);
        // jumps and branches against the static guess
        op(cls_jal, 3'd0, 64'h40, 64'd0, 64'd0);
        op(cls_jalr, 3'd0, 64'h11, 64'h3000, 64'd0);
        op(cls_branch, 3'd0, 64'h20, 64'd7, 64'd7);
        op(cls_branch, 3'd4, -64'sd32, -64'sd1, 64'd1);
        op(cls_branch, 3'd7, 64'h20, 64'd1, 64'd2);
        op(cls_branch, 3'd6, -64'sd16, 64'd5, 64'd2);
        // both stages hit, then x0, then an immediate form with an rs2 hit
        step(make_rec(cls_alu_reg, 3'd0, 0, 1, 2, 5'd3, 5'd3), 1, 1, 0, '0, '0);
        step('0, 0, 1, 0, {1'b1, 5'd3, 64'h111}, {1'b1, 5'd3, 64'h222});
        step(make_rec(cls_store, 3'd3, 0, 1, 2, 5'd0, 5'd0), 1, 1, 0, '0, '0);
        step('0, 0, 1, 0, {1'b1, 5'd0, 64'h333}, {1'b1, 5'd0, 64'h444});
        step(make_rec(cls_alu_imm, 3'd0, 4, 1, 2, 5'd1, 5'd4), 1, 1, 0, '0, '0);
        step('0, 0, 1, 0, {1'b1, 5'd4, 64'h555}, {1'b1, 5'd4, 64'h666});
        // memory stalls a redirecting jump, then releases it
        op(cls_jal, 3'd0, 64'h80, 64'd0, 64'd0);
        repeat (3) step(make_rec(cls_alu_reg, 3'd0, 0, 1, 2, 5'd1, 5'd2), 1, 0, 0, '0, '0);
        op(cls_alu_reg, 3'd4, 64'd0, 64'd6, 64'd3);
        // flush while memory is stalled
        op(cls_alu_reg, 3'd0, 64'd0, 64'd8, 64'd8);
        step(make_rec(cls_jal, 3'd0, 8, 0, 0, 5'd1, 5'd2), 1, 0, 1, '0, '0);
        step('0, 0, 1, 0, '0, '0);
        for (int i = 0; i < n_random; i++) begin
            random_cycle();
        end
        step('0, 0, 1, 0, '0, '0);
        repeat (3) @(posedge clk);
        if (u_dut.u_assert.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "protocol violation");
        end
    end

endmodule

// ==== sources.f ====
common/exu_pkg.sv
execute/exu_stage_reg.sv
execute/exu_bypass.sv
execute/exu_alu.sv
execute/exu_branch.sv
source/exu_top.sv
sim/exu_assert.sv
sim/exu_tb.sv

// ==== Bender.yml ====
package:
  name: exu

sources:
  - common/exu_pkg.sv
  - execute/exu_stage_reg.sv
  - execute/exu_bypass.sv
  - execute/exu_alu.sv
  - execute/exu_branch.sv
  - source/exu_top.sv
  - target: simulation
    files:
      - sim/exu_assert.sv
      - sim/exu_tb.sv
